// File: source/vlane_pkg.sv
package vlane_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Cluster dimensions
    parameter int VLANE_NUM       = 8;
    parameter int MAX_VL_PER_LANE = 256;
    parameter int MEM_DEPTH       = 512;                 // Words per lane
    parameter int RPORT_NUM       = 3;                   // vs1, vs2, vs3

    ////////////////////////////////////////////////////////////////////////////
    // Width types
    typedef logic [$clog2(VLANE_NUM * MAX_VL_PER_LANE):0] vl_t;
    typedef logic [$clog2(MAX_VL_PER_LANE) + 1:0]         step_t;  // Holds delay plus length
    typedef logic [$clog2(MEM_DEPTH) - 1:0]               vrf_addr_t;
    typedef logic [$clog2(MEM_DEPTH) - 1:0]               vrf_base_t;
    typedef logic [3:0]                                   bwen_t;
    typedef logic [VLANE_NUM - 1:0]                       lane_bits_t;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        NORMAL,
        STORE,
        LOAD
    } cmd_kind_e;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        STORE_READ,
        LOAD_WRITE
    } seq_state_e;

    // Operand and opcode bundle, forwarded untouched to the lanes
    typedef struct packed {
        logic [1:0]                     op2_sel;
        logic [$clog2(RPORT_NUM) - 1:0] op3_sel;
        logic [31:0]                    scalar_data;
        logic [4:0]                     imm;
        logic [5:0]                     opmode;
        logic                           vector_mask;
    } alu_ctrl_s;

    typedef struct packed {
        cmd_kind_e                   kind;
        vl_t                         vl;
        elem_width_e                 width;
        step_t                       delay;      // Read to write pipeline latency
        vrf_base_t                   wr_base;
        vrf_base_t [RPORT_NUM - 1:0] rd_base;
        alu_ctrl_s                   alu;
    } vec_cmd_s;

endpackage

// File: source/vrf_addr_counter.sv
module vrf_addr_counter #(
    parameter int MEM_DEPTH = vlane_pkg::MEM_DEPTH
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  vlane_pkg::vrf_base_t   base_i,
    input  logic                   load_i,
    input  logic                   adv_i,
    input  vlane_pkg::elem_width_e width_i,
    output vlane_pkg::vrf_addr_t   addr_o
);
    import vlane_pkg::*;

    vrf_addr_t  addr_q;
    logic [1:0] sub_q;       // Elements already placed in the current word
    logic [1:0] sub_last;

    // Elements per word minus one
    always_comb begin
        case (width_i)
            BYTE:    sub_last = 2'd3;
            HALF:    sub_last = 2'd1;
            default: sub_last = 2'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            sub_q  <= '0;
        end else if (load_i) begin
            addr_q <= vrf_addr_t'(base_i);
            sub_q  <= '0;
        end else if (adv_i) begin
            if (sub_q == sub_last) begin
                sub_q  <= '0;
                addr_q <= (addr_q == vrf_addr_t'(MEM_DEPTH - 1)) ? '0 : addr_q + 1'b1;
            end else begin
                sub_q <= sub_q + 1'b1;
            end
        end
    end

    assign addr_o = addr_q;

endmodule

// File: source/bwen_gen.sv
module bwen_gen #(
    parameter int VLANE_NUM = vlane_pkg::VLANE_NUM
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    adv_i,
    input  logic                                    clear_i,
    input  vlane_pkg::elem_width_e                  width_i,
    output vlane_pkg::bwen_t [VLANE_NUM - 1:0]      bwen_o
);
    import vlane_pkg::*;

    logic [3:0] rot4_q;      // One-hot byte select
    logic [1:0] rot2_q;      // One-hot halfword select
    bwen_t      mask;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (clear_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (adv_i) begin
            rot4_q <= {rot4_q[2:0], rot4_q[3]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end
    end

    always_comb begin
        case (width_i)
            BYTE:    mask = rot4_q;
            HALF:    mask = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
            WORD:    mask = 4'b1111;
            default: mask = 4'b0000;
        endcase
    end

    // Every lane writes the same byte lanes
    assign bwen_o = {VLANE_NUM{mask}};

    // A write step issued by the sequencer must touch at least one byte
    a_bwen_nonzero : assert property (@(posedge clk_i) disable iff (!rst_i)
        adv_i |-> (mask != '0));

endmodule

// File: source/tail_valid_gen.sv
module tail_valid_gen #(
    parameter int VLANE_NUM = vlane_pkg::VLANE_NUM
) (
    input  vlane_pkg::vl_t        vl_i,
    input  vlane_pkg::step_t      step_i,
    input  logic                  active_i,
    output vlane_pkg::lane_bits_t valid_o
);
    import vlane_pkg::*;

    localparam int IDX_W = $bits(step_t) + $clog2(VLANE_NUM) + 1;

    logic [IDX_W - 1:0] group_base;   // Index of lane 0 element at this step

    ////////////////////////////////////////////////////////////////////////////
    // Element k*N+j sits in lane j at step k

    assign group_base = IDX_W'(step_i) * IDX_W'(VLANE_NUM);

    always_comb begin
        for (int j = 0; j < VLANE_NUM; j++) begin
            valid_o[j] = active_i && ((group_base + IDX_W'(j)) < IDX_W'(vl_i));
        end
    end

endmodule

// File: source/lane_seq_fsm.sv
module lane_seq_fsm #(
    parameter int VLANE_NUM = vlane_pkg::VLANE_NUM
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  vlane_pkg::vec_cmd_s cmd_i,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  logic                load_valid_i,
    input  logic                load_last_i,
    output logic                load_ready_o,
    output logic                store_valid_o,
    input  logic                store_ready_i,
    output vlane_pkg::vec_cmd_s cmd_o,
    output vlane_pkg::step_t    step_o,
    output logic                rd_load_o,
    output logic                rd_adv_o,
    output logic                wr_load_o,
    output logic                wr_adv_o,
    output logic                vrf_ren_o,
    output logic                vrf_wen_o,
    output logic                use_load_bwen_o,
    output logic                vmrf_wen_o,
    output vlane_pkg::step_t    vmrf_addr_o
);
    import vlane_pkg::*;

    localparam int LANE_SHIFT = $clog2(VLANE_NUM);

    seq_state_e state_q;
    seq_state_e state_d;
    vec_cmd_s   cmd_q;
    step_t      step_q;
    step_t      len_q;         // Elements per lane
    step_t      end_q;         // Delay plus length
    step_t      vm_addr_q;
    step_t      len_new;
    logic       cmd_accept;
    logic       store_hs;
    logic       load_hs;

    ////////////////////////////////////////////////////////////////////////////
    // Handshakes and strobes

    // Partial last element group rounds L up
    assign len_new = step_t'(cmd_i.vl >> LANE_SHIFT) + step_t'(|cmd_i.vl[LANE_SHIFT - 1:0]);

    assign cmd_ready_o     = (state_q == IDLE);
    assign cmd_accept      = cmd_valid_i && cmd_ready_o;
    assign load_ready_o    = (state_q == LOAD_WRITE);
    assign use_load_bwen_o = load_ready_o;
    assign load_hs         = load_valid_i && load_ready_o;
    assign store_valid_o   = (state_q == STORE_READ) && (step_q < len_q);
    assign store_hs        = store_valid_o && store_ready_i;

    assign vrf_ren_o  = ((state_q == EXEC) && (step_q < len_q)) || store_valid_o;
    assign vrf_wen_o  = ((state_q == EXEC) && (step_q >= cmd_q.delay) && (step_q < end_q))
                        || load_hs;
    assign vmrf_wen_o = vrf_wen_o && (state_q == EXEC) && cmd_q.alu.vector_mask;

    // Counters pick up the bases on the accepting edge
    assign rd_load_o = cmd_accept;
    assign wr_load_o = cmd_accept;
    assign rd_adv_o  = (state_q == EXEC) ? vrf_ren_o : store_hs;  // Store holds on stall
    assign wr_adv_o  = vrf_wen_o;

    assign cmd_o       = cmd_q;
    assign step_o      = step_q;
    assign vmrf_addr_o = vm_addr_q;

    ////////////////////////////////////////////////////////////////////////////
    // State machine

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_accept) begin
                    case (cmd_i.kind)
                        STORE:   state_d = STORE_READ;
                        LOAD:    state_d = LOAD_WRITE;
                        default: state_d = EXEC;
                    endcase
                end
            end
            EXEC: begin
                if (step_q + step_t'(1) >= end_q) state_d = IDLE;   // Last write step
            end
            STORE_READ: begin
                if (!store_valid_o || (store_ready_i && (step_q + step_t'(1) >= len_q))) begin
                    state_d = IDLE;
                end
            end
            LOAD_WRITE: begin
                if (load_hs && load_last_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= IDLE;
            step_q    <= '0;
            vm_addr_q <= '0;
        end else begin
            state_q <= state_d;
            if (cmd_accept) begin
                step_q    <= '0;
                vm_addr_q <= '0;
            end else begin
                if ((state_q == EXEC) || store_hs) step_q <= step_q + 1'b1;
                if (vmrf_wen_o) vm_addr_q <= vm_addr_q + 1'b1;
            end
        end
    end

    // Command latch
    always_ff @(posedge clk_i) begin
        if (cmd_accept) begin
            cmd_q <= cmd_i;
            len_q <= len_new;
            end_q <= cmd_i.delay + len_new;
            if (cmd_i.kind != NORMAL) cmd_q.width <= WORD;   // Memory moves whole words
        end
    end

    // A busy sequencer takes no new command
    a_busy_holds_cmd : assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q != IDLE) |=> $stable(cmd_q) && $stable(len_q));

    a_step_bound : assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == EXEC) |-> (step_q <= end_q));

endmodule

// File: source/lane_driver_top.sv
module lane_driver_top #(
    parameter int VLANE_NUM = vlane_pkg::VLANE_NUM,
    parameter int MEM_DEPTH = vlane_pkg::MEM_DEPTH,
    parameter int RPORT_NUM = vlane_pkg::RPORT_NUM
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  vlane_pkg::vec_cmd_s                   cmd_i,
    input  logic                                  cmd_valid_i,
    output logic                                  cmd_ready_o,
    input  vlane_pkg::bwen_t [VLANE_NUM - 1:0]    load_bwen_i,
    input  logic                                  load_valid_i,
    input  logic                                  load_last_i,
    output logic                                  load_ready_o,
    output logic                                  store_valid_o,
    input  logic                                  store_ready_i,
    output logic                                  vrf_ren_o,
    output vlane_pkg::vrf_addr_t [RPORT_NUM - 1:0] vrf_raddr_o,
    output vlane_pkg::lane_bits_t                 read_valid_o,
    output logic                                  vrf_wen_o,
    output vlane_pkg::vrf_addr_t                  vrf_waddr_o,
    output vlane_pkg::bwen_t [VLANE_NUM - 1:0]    vrf_bwen_o,
    output logic                                  vmrf_wen_o,
    output vlane_pkg::step_t                      vmrf_addr_o,
    output vlane_pkg::alu_ctrl_s                  alu_ctrl_o
);
    import vlane_pkg::*;

    vec_cmd_s              cmd_q;
    step_t                 step;
    logic                  rd_load;
    logic                  rd_adv;
    logic                  wr_load;
    logic                  wr_adv;
    logic                  use_load_bwen;
    bwen_t [VLANE_NUM - 1:0] gen_bwen;

    lane_seq_fsm #(.VLANE_NUM(VLANE_NUM)) i_seq (
        .clk_i, .rst_i, .cmd_i, .cmd_valid_i, .cmd_ready_o,
        .load_valid_i, .load_last_i, .load_ready_o, .store_valid_o, .store_ready_i,
        .cmd_o(cmd_q), .step_o(step),
        .rd_load_o(rd_load), .rd_adv_o(rd_adv), .wr_load_o(wr_load), .wr_adv_o(wr_adv),
        .vrf_ren_o, .vrf_wen_o, .use_load_bwen_o(use_load_bwen),
        .vmrf_wen_o, .vmrf_addr_o
    );

    ////////////////////////////////////////////////////////////////////////////
    // Address counters load from the incoming command, ready in cycle 1

    vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) i_waddr (
        .clk_i, .rst_i, .base_i(cmd_i.wr_base), .load_i(wr_load), .adv_i(wr_adv),
        .width_i(cmd_q.width), .addr_o(vrf_waddr_o)
    );

    for (genvar p = 0; p < RPORT_NUM; p++) begin : g_raddr
        vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) i_raddr (
            .clk_i, .rst_i, .base_i(cmd_i.rd_base[p]), .load_i(rd_load), .adv_i(rd_adv),
            .width_i(cmd_q.width), .addr_o(vrf_raddr_o[p])
        );
    end

    bwen_gen #(.VLANE_NUM(VLANE_NUM)) i_bwen (
        .clk_i, .rst_i, .adv_i(wr_adv), .clear_i(wr_load),
        .width_i(cmd_q.width), .bwen_o(gen_bwen)
    );

    tail_valid_gen #(.VLANE_NUM(VLANE_NUM)) i_tail (
        .vl_i(cmd_q.vl), .step_i(step), .active_i(vrf_ren_o), .valid_o(read_valid_o)
    );

    assign vrf_bwen_o = use_load_bwen ? load_bwen_i : gen_bwen;   // Load beats bring own enables
    assign alu_ctrl_o = cmd_q.alu;

endmodule

// File: verification/lane_driver_model.svh
`ifndef LANE_DRIVER_MODEL_SVH
`define LANE_DRIVER_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model

// Elements per lane, partial last group counts as a step
function automatic int lane_len(int vl);
    return (vl + VLANE_NUM - 1) / VLANE_NUM;
endfunction

function automatic vrf_addr_t exp_addr(vrf_base_t base, int k, elem_width_e w);
    int per_word;
    per_word = (w == BYTE) ? 4 : ((w == HALF) ? 2 : 1);
    return vrf_addr_t'((base + k / per_word) % MEM_DEPTH);   // Wraps at the top word
endfunction

function automatic bwen_t exp_bwen(int j, elem_width_e w);
    if (w == BYTE) return bwen_t'(1 << (j % 4));
    if (w == HALF) return ((j % 2) == 0) ? 4'b0011 : 4'b1100;
    return 4'b1111;
endfunction

// Lane j holds element k*N+j
function automatic lane_bits_t exp_lanes(int vl, int k);
    lane_bits_t v;
    for (int j = 0; j < VLANE_NUM; j++) v[j] = ((k * VLANE_NUM + j) < vl);
    return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks

task automatic report_mismatch(string what, logic [63:0] exp, logic [63:0] act);
    $display("mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
    test_errs++;
endtask

task automatic check_addr(string what, vrf_addr_t exp, vrf_addr_t act);
    if (act !== exp) report_mismatch(what, exp, act);
endtask

task automatic check_bwen(string what, bwen_t exp, bwen_t act);
    if (act !== exp) report_mismatch(what, exp, act);
endtask

task automatic check_lanes(string what, lane_bits_t exp, lane_bits_t act);
    if (act !== exp) report_mismatch(what, exp, act);
endtask

task automatic check_alu(string what, alu_ctrl_s exp, alu_ctrl_s act);
    if (act !== exp) report_mismatch(what, exp, act);
endtask

task automatic check_step(string what, step_t exp, step_t act);
    if (act !== exp) report_mismatch(what, exp, act);
endtask

task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) report_mismatch(what, exp, act);
endtask

`endif

// File: verification/lane_driver_tb.sv
module lane_driver_tb;
    import vlane_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int N_TESTS         = 60;
    localparam int D_MAX           = 15;
    localparam int VL_MAX          = 64;
    localparam int L_MAX           = (VL_MAX + VLANE_NUM - 1) / VLANE_NUM;
    localparam int ALU_W           = $bits(alu_ctrl_s);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_TESTS * (D_MAX + L_MAX + 20);

    logic                              clk;
    logic                              rst;
    vec_cmd_s                          cmd;
    logic                              cmd_valid;
    logic                              cmd_ready;
    bwen_t [VLANE_NUM - 1:0]           load_bwen;
    logic                              load_valid;
    logic                              load_last;
    logic                              load_ready;
    logic                              store_valid;
    logic                              store_ready;
    logic                              vrf_ren;
    vrf_addr_t [RPORT_NUM - 1:0]       vrf_raddr;
    lane_bits_t                        read_valid;
    logic                              vrf_wen;
    vrf_addr_t                         vrf_waddr;
    bwen_t [VLANE_NUM - 1:0]           vrf_bwen;
    logic                              vmrf_wen;
    step_t                             vmrf_addr;
    alu_ctrl_s                         alu_ctrl;

    string test_name;
    int    test_errs;
    int    err_count;
    int    fail_tests;
    string kind_names [3] = '{"normal", "store", "load"};

    `include "lane_driver_model.svh"

    lane_driver_top #(.VLANE_NUM(VLANE_NUM), .MEM_DEPTH(MEM_DEPTH), .RPORT_NUM(RPORT_NUM)) i_dut (
        .clk_i(clk), .rst_i(rst), .cmd_i(cmd), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
        .load_bwen_i(load_bwen), .load_valid_i(load_valid), .load_last_i(load_last),
        .load_ready_o(load_ready), .store_valid_o(store_valid), .store_ready_i(store_ready),
        .vrf_ren_o(vrf_ren), .vrf_raddr_o(vrf_raddr), .read_valid_o(read_valid),
        .vrf_wen_o(vrf_wen), .vrf_waddr_o(vrf_waddr), .vrf_bwen_o(vrf_bwen),
        .vmrf_wen_o(vmrf_wen), .vmrf_addr_o(vmrf_addr), .alu_ctrl_o(alu_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    task automatic finish_test();
        err_count += test_errs;
        if (test_errs != 0) fail_tests++;
        $display("test %s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "failed",
                 test_errs);
        test_errs = 0;
    endtask

    // Random beat with last set only on the final planned beat
    task automatic drive_beat(int beats, int n_beats);
        load_valid = ($urandom_range(0, 3) != 0);
        load_bwen  = $urandom;
        load_last  = (beats == n_beats - 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One random command entered and left on a falling edge

    task automatic run_command(int t);
        vec_cmd_s    c;
        elem_width_e w;
        int          len;
        int          dly;
        int          cnt;
        int          n_beats;
        c.kind  = cmd_kind_e'(t % 3);
        c.vl    = vl_t'($urandom_range(1, VL_MAX));
        c.width = elem_width_e'($urandom_range(0, 2));
        c.delay = step_t'($urandom_range(0, D_MAX));
        c.wr_base = vrf_base_t'($urandom);
        for (int p = 0; p < RPORT_NUM; p++) c.rd_base[p] = vrf_base_t'($urandom);
        c.alu = ALU_W'({$urandom, $urandom});
        w = c.width;
        if (c.kind != NORMAL) w = WORD;            // Memory traffic moves whole words
        len = lane_len(c.vl);
        dly = c.delay;
        test_name = $sformatf("%s_%0d", kind_names[t % 3], t);
        cmd       = c;
        cmd_valid = 1'b1;
        #1 check_flag("cmd_ready_o before accept", 1'b1, cmd_ready);
        @(negedge clk);
        cmd_valid = 1'b0;
        if (c.kind == NORMAL) begin
            for (int cyc = 1; cyc <= dly + len + 1; cyc++) begin
                #1;
                check_flag("cmd_ready_o", cyc == dly + len + 1, cmd_ready);
                check_alu("alu_ctrl_o", c.alu, alu_ctrl);
                check_flag("vrf_ren_o", cyc <= len, vrf_ren);
                check_flag("vrf_wen_o", (cyc > dly) && (cyc <= dly + len), vrf_wen);
                check_flag("vmrf_wen_o", (cyc > dly) && (cyc <= dly + len) && c.alu.vector_mask,
                           vmrf_wen);
                check_lanes("read_valid_o", (cyc <= len) ? exp_lanes(c.vl, cyc - 1) : '0,
                            read_valid);
                if (cyc <= len) begin
                    for (int p = 0; p < RPORT_NUM; p++)
                        check_addr("vrf_raddr_o", exp_addr(c.rd_base[p], cyc - 1, w), vrf_raddr[p]);
                end
                if ((cyc > dly) && (cyc <= dly + len)) begin
                    check_addr("vrf_waddr_o", exp_addr(c.wr_base, cyc - dly - 1, w), vrf_waddr);
                    for (int j = 0; j < VLANE_NUM; j++)
                        check_bwen("vrf_bwen_o", exp_bwen(cyc - dly - 1, w), vrf_bwen[j]);
                    if (c.alu.vector_mask)
                        check_step("vmrf_addr_o", step_t'(cyc - dly - 1), vmrf_addr);
                end
                @(negedge clk);
            end
        end else if (c.kind == STORE) begin
            cnt = 0;
            store_ready = ($urandom_range(0, 3) != 0);
            #1;
            while (!cmd_ready) begin
                check_flag("store_valid_o", 1'b1, store_valid);
                check_flag("vrf_ren_o", 1'b1, vrf_ren);
                check_flag("vrf_wen_o", 1'b0, vrf_wen);
                check_flag("vmrf_wen_o", 1'b0, vmrf_wen);
                check_lanes("read_valid_o", exp_lanes(c.vl, cnt), read_valid);
                for (int p = 0; p < RPORT_NUM; p++)
                    check_addr("vrf_raddr_o", exp_addr(c.rd_base[p], cnt, w), vrf_raddr[p]);
                if (store_ready) cnt++;
                @(negedge clk);
                store_ready = ($urandom_range(0, 3) != 0);
                #1;
            end
            if (cnt != len) report_mismatch("store handshakes", len, cnt);
            check_flag("store_valid_o after end", 1'b0, store_valid);
            @(negedge clk);
        end else begin
            cnt     = 0;
            n_beats = $urandom_range(1, L_MAX);
            drive_beat(cnt, n_beats);
            #1;
            while (!cmd_ready) begin
                check_flag("load_ready_o", 1'b1, load_ready);
                check_flag("vrf_ren_o", 1'b0, vrf_ren);
                check_flag("vrf_wen_o", load_valid, vrf_wen);
                check_flag("vmrf_wen_o", 1'b0, vmrf_wen);
                if (load_valid) begin
                    check_addr("vrf_waddr_o", exp_addr(c.wr_base, cnt, w), vrf_waddr);
                    for (int j = 0; j < VLANE_NUM; j++)
                        check_bwen("vrf_bwen_o", load_bwen[j], vrf_bwen[j]);
                    cnt++;
                end
                @(negedge clk);
                drive_beat(cnt, n_beats);
                #1;
            end
            if (cnt != n_beats) report_mismatch("load beats", n_beats, cnt);
            check_flag("load_ready_o after end", 1'b0, load_ready);
            @(negedge clk);
            load_valid = 1'b0;
            load_last  = 1'b0;
        end
        check_alu("alu_ctrl_o after end", c.alu, alu_ctrl);
        finish_test();
    endtask

    initial begin
        int seed_init;
        seed_init   = $urandom(32'h60e3);
        test_errs   = 0;
        err_count   = 0;
        fail_tests  = 0;
        rst         = 1'b0;
        cmd         = '0;
        cmd_valid   = 1'b0;
        load_bwen   = '0;
        load_valid  = 1'b0;
        load_last   = 1'b0;
        store_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        test_name = "reset";
        #1;
        check_flag("cmd_ready_o", 1'b1, cmd_ready);
        check_flag("vrf_ren_o", 1'b0, vrf_ren);
        check_flag("vrf_wen_o", 1'b0, vrf_wen);
        check_flag("vmrf_wen_o", 1'b0, vmrf_wen);
        check_flag("store_valid_o", 1'b0, store_valid);
        check_flag("load_ready_o", 1'b0, load_ready);
        finish_test();
        @(negedge clk);
        for (int t = 0; t < N_TESTS; t++) run_command(t);
        $display("tests run %0d, tests failed %0d, checks failed %0d", N_TESTS + 1, fail_tests,
                 err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
source/vlane_pkg.sv
source/vrf_addr_counter.sv
source/bwen_gen.sv
source/tail_valid_gen.sv
source/lane_seq_fsm.sv
source/lane_driver_top.sv
verification/lane_driver_tb.sv

// File: Bender.yml
package:
  name: lane_driver

sources:
  - source/vlane_pkg.sv
  - source/vrf_addr_counter.sv
  - source/bwen_gen.sv
  - source/tail_valid_gen.sv
  - source/lane_seq_fsm.sv
  - source/lane_driver_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/lane_driver_tb.sv
